// ==== src/nib_defs.svh ====
////////////////////////////////////////////////////////////
// Nibble stream buffer: widths and sizes shared by the
// packages and the datapath modules
////////////////////////////////////////////////////////////

`ifndef NIB_DEFS_SVH
`define NIB_DEFS_SVH

// Nibble width, a FIFO word holds two of them
`define NIB_W 4

// Words held by the FIFO
`define FIFO_DEPTH 16

// Pointer index width, pointers add a wrap bit on top
`define FIFO_ADDRW 4

// Register address width
`define REG_ADDRW 2

`endif

// ==== src/nib_data_pkg.sv ====
////////////////////////////////////////////////////////////
// Data types of the nibble stream: nibble pair and FIFO word
////////////////////////////////////////////////////////////

`default_nettype none

`include "nib_defs.svh"

package nib_data_pkg;

  // Two nibbles of one word, hi in the upper half
  typedef struct packed {
    logic [`NIB_W-1:0] hi;
    logic [`NIB_W-1:0] lo;
  } nib_pair_s;

  // One FIFO word, seen as a byte or as a nibble pair
  typedef union packed {
    logic [2*`NIB_W-1:0] as_byte;
    nib_pair_s           as_nib;
  } fifo_word_u;

endpackage

`default_nettype wire

// ==== src/nib_reg_pkg.sv ====
////////////////////////////////////////////////////////////
// Register map of the stream control block
////////////////////////////////////////////////////////////

`default_nettype none

`include "nib_defs.svh"

package nib_reg_pkg;

  // Register addresses
  typedef enum logic [`REG_ADDRW-1:0] {
    REG_CTRL   = 2'd0,
    REG_STATUS = 2'd1,
    REG_DROPS  = 2'd2,
    REG_HEAD   = 2'd3
  } reg_addr_e;

  // Control word fields
  localparam int CTRL_HI_FIRST = 0;
  localparam int CTRL_FLUSH    = 1;

  // Status word flags, level sits in the low bits
  localparam int STAT_EMPTY = 6;
  localparam int STAT_FULL  = 7;

endpackage

`default_nettype wire

// ==== src/nibble_packer.sv ====
////////////////////////////////////////////////////////////
// Nibble packer: joins two input nibbles into one FIFO word
// and writes it, or flags a drop when the FIFO is full
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module nibble_packer
  import nib_data_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              nrst,
  input  wire logic              flush_i,
  input  wire logic              hi_first_i,
  input  wire logic              nib_valid_i,
  input  wire logic [`NIB_W-1:0] nib_i,
  input  wire logic              full_i,
  output fifo_word_u             din_o,
  output logic                   wr_o,
  output logic                   drop_o
);

  // Set while the first nibble of a pair is held
  logic              phase_q;
  logic [`NIB_W-1:0] first_q;
  logic              complete;

  // Second nibble of the pair arriving now
  assign complete = nib_valid_i & phase_q;

  assign wr_o   = complete & ~full_i;
  assign drop_o = complete & full_i;

  // Place the held nibble in the field that goes out first
  always_comb begin
    if (hi_first_i) begin
      din_o.as_nib.hi = first_q;
      din_o.as_nib.lo = nib_i;
    end else begin
      din_o.as_nib.hi = nib_i;
      din_o.as_nib.lo = first_q;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0;
    end else if (nib_valid_i) begin
      phase_q <= ~phase_q;
    end
  end

  // First nibble of the pair, captured in phase 0
  always_ff @(posedge clk) begin
    if (nib_valid_i && !phase_q) begin
      first_q <= nib_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/fifo_buffer.sv ====
////////////////////////////////////////////////////////////
// Word FIFO: synchronous write, asynchronous read, wrap-bit
// pointers, synchronous flush and level output
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module fifo_buffer
  import nib_data_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               nrst,
  input  wire logic               reset_i,
  input  wire logic               wr_i,
  input  fifo_word_u              din_i,
  input  wire logic               rd_i,
  output fifo_word_u              dout_o,
  output logic                    empty_o,
  output logic                    full_o,
  output logic [`FIFO_ADDRW:0]    level_o
);

  localparam int AW = `FIFO_ADDRW;

  // Storage
  fifo_word_u mem [`FIFO_DEPTH];

  // Top bit of each pointer is the wrap bit
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;
  logic          same_idx;

  assign wr_idx   = wr_ptr[AW-1:0];
  assign rd_idx   = rd_ptr[AW-1:0];
  assign same_idx = (wr_idx == rd_idx);

  // Flags from the pointer compare
  assign empty_o = same_idx & (wr_ptr[AW] == rd_ptr[AW]);
  assign full_o  = same_idx & (wr_ptr[AW] != rd_ptr[AW]);

  // Wrap bit makes the plain difference the fill level
  assign level_o = wr_ptr - rd_ptr;

  // Head word straight from the array
  assign dout_o = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_idx] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
    end else if (reset_i) begin
      wr_ptr <= '0;
    end else if (wr_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      rd_ptr <= '0;
    end else if (reset_i) begin
      rd_ptr <= '0;
    end else if (rd_i) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/nibble_unpacker.sv ====
////////////////////////////////////////////////////////////
// Nibble unpacker: hands out the head word's nibbles in
// stream order and pops the word after the second one
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module nibble_unpacker
  import nib_data_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              nrst,
  input  wire logic              flush_i,
  input  wire logic              hi_first_i,
  input  fifo_word_u             dout_i,
  input  wire logic              empty_i,
  input  wire logic              nib_take_i,
  output logic                   nib_valid_o,
  output logic [`NIB_W-1:0]      nib_o,
  output logic                   rd_o
);

  // Set once the first nibble of the head word is taken
  logic phase_q;
  logic take;
  logic sel_lo;

  assign nib_valid_o = ~empty_i;

  // Takes with nothing stored are dropped here
  assign take = nib_take_i & ~empty_i;

  // Low field goes out when the phase matches hi_first
  //   hi first: phase 0 -> hi, phase 1 -> lo
  //   lo first: phase 0 -> lo, phase 1 -> hi
  assign sel_lo = (phase_q == hi_first_i);

  always_comb begin
    if (sel_lo) begin
      nib_o = dout_i.as_nib.lo;
    end else begin
      nib_o = dout_i.as_nib.hi;
    end
  end

  // Second take releases the word
  assign rd_o = take & phase_q;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0;
    end else if (take) begin
      phase_q <= ~phase_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/stream_regs.sv ====
////////////////////////////////////////////////////////////
// Stream registers: nibble order, flush pulse, drop count
// and FIFO status for the register port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module stream_regs
  import nib_data_pkg::*;
  import nib_reg_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   nrst,
  input  wire logic                   reg_we_i,
  input  wire logic [`REG_ADDRW-1:0]  reg_addr_i,
  input  wire logic [2*`NIB_W-1:0]    reg_wdata_i,
  output logic [2*`NIB_W-1:0]         reg_rdata_o,
  input  wire logic [`FIFO_ADDRW:0]   level_i,
  input  wire logic                   empty_i,
  input  wire logic                   full_i,
  input  fifo_word_u                  head_i,
  input  wire logic                   drop_i,
  output logic                        hi_first_o,
  output logic                        flush_o
);

  localparam int DW = 2 * `NIB_W;

  reg_addr_e     addr;
  logic          ctrl_we;
  logic [DW-1:0] drops_q;
  logic [DW-1:0] status;
  logic [DW-1:0] ctrl;

  assign addr    = reg_addr_e'(reg_addr_i);
  assign ctrl_we = reg_we_i && (addr == REG_CTRL);

  // Control register and the one-cycle flush
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      hi_first_o <= 1'b1;
      flush_o    <= 1'b0;
    end else begin
      flush_o <= ctrl_we & reg_wdata_i[CTRL_FLUSH];
      if (ctrl_we) begin
        hi_first_o <= reg_wdata_i[CTRL_HI_FIRST];
      end
    end
  end

  // Drop counter holds at all ones
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      drops_q <= '0;
    end else if (drop_i && (drops_q != {DW{1'b1}})) begin
      drops_q <= drops_q + 1'b1;
    end
  end

  // Flush bit always reads back as zero
  always_comb begin
    ctrl                = '0;
    ctrl[CTRL_HI_FIRST] = hi_first_o;
  end

  always_comb begin
    status                           = '0;
    status[`FIFO_ADDRW:0]            = level_i;
    status[STAT_EMPTY]               = empty_i;
    status[STAT_FULL]                = full_i;
  end

  // Read mux
  always_comb begin
    case (addr)
      REG_CTRL:   reg_rdata_o = ctrl;
      REG_STATUS: reg_rdata_o = status;
      REG_DROPS:  reg_rdata_o = drops_q;
      REG_HEAD:   reg_rdata_o = head_i.as_byte;
      default:    reg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/nibble_stream_top.sv ====
////////////////////////////////////////////////////////////
// Nibble stream buffer top: packer, FIFO, unpacker, registers
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module nibble_stream_top
  import nib_data_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   nrst,
  input  wire logic                   nib_valid_i,
  input  wire logic [`NIB_W-1:0]      nib_i,
  input  wire logic                   nib_take_i,
  output logic                        nib_valid_o,
  output logic [`NIB_W-1:0]           nib_o,
  input  wire logic                   reg_we_i,
  input  wire logic [`REG_ADDRW-1:0]  reg_addr_i,
  input  wire logic [2*`NIB_W-1:0]    reg_wdata_i,
  output logic [2*`NIB_W-1:0]         reg_rdata_o
);

  logic                 flush;
  logic                 hi_first;
  logic                 wr;
  logic                 rd;
  logic                 drop;
  logic                 empty;
  logic                 full;
  logic [`FIFO_ADDRW:0] level;
  fifo_word_u           din;
  fifo_word_u           dout;

  nibble_packer u_packer (
    .clk(clk), .nrst(nrst), .flush_i(flush), .hi_first_i(hi_first),
    .nib_valid_i(nib_valid_i), .nib_i(nib_i), .full_i(full),
    .din_o(din), .wr_o(wr), .drop_o(drop)
  );

  fifo_buffer u_fifo (
    .clk(clk), .nrst(nrst), .reset_i(flush),
    .wr_i(wr), .din_i(din), .rd_i(rd), .dout_o(dout),
    .empty_o(empty), .full_o(full), .level_o(level)
  );

  nibble_unpacker u_unpacker (
    .clk(clk), .nrst(nrst), .flush_i(flush), .hi_first_i(hi_first),
    .dout_i(dout), .empty_i(empty), .nib_take_i(nib_take_i),
    .nib_valid_o(nib_valid_o), .nib_o(nib_o), .rd_o(rd)
  );

  stream_regs u_regs (
    .clk(clk), .nrst(nrst),
    .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .level_i(level), .empty_i(empty), .full_i(full), .head_i(dout),
    .drop_i(drop), .hi_first_o(hi_first), .flush_o(flush)
  );

endmodule

`default_nettype wire

// ==== testbench/fifo_buffer_chk.sv ====
////////////////////////////////////////////////////////////
// FIFO checker: pointer, flag and reset rules of fifo_buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module fifo_buffer_chk (
  input wire logic                 clk,
  input wire logic                 nrst,
  input wire logic                 reset_i,
  input wire logic                 wr_i,
  input wire logic                 rd_i,
  input wire logic                 empty_i,
  input wire logic                 full_i,
  input wire logic [`FIFO_ADDRW:0] wr_ptr_i,
  input wire logic [`FIFO_ADDRW:0] rd_ptr_i
);

  localparam int AW = `FIFO_ADDRW;
  localparam logic [AW:0] DEPTH = `FIFO_DEPTH;

  // Failed assertions so far
  int fail_cnt = 0;

  a_no_wr_full: assert property (@(posedge clk) disable iff (!nrst) wr_i |-> !full_i)
    else begin $error("write while full"); fail_cnt++; end

  a_no_rd_empty: assert property (@(posedge clk) disable iff (!nrst) rd_i |-> !empty_i)
    else begin $error("read while empty"); fail_cnt++; end

  a_empty: assert property (@(posedge clk) disable iff (!nrst)
    empty_i == (wr_ptr_i == rd_ptr_i))
    else begin $error("empty flag does not match pointers"); fail_cnt++; end

  // Full when the pointers are a whole depth apart
  a_full: assert property (@(posedge clk) disable iff (!nrst)
    full_i == ((wr_ptr_i - rd_ptr_i) == DEPTH))
    else begin $error("full flag does not match pointers"); fail_cnt++; end

  a_flags: assert property (@(posedge clk) disable iff (!nrst) !(empty_i && full_i))
    else begin $error("empty and full both high"); fail_cnt++; end

  a_wr_step: assert property (@(posedge clk) disable iff (!nrst)
    !reset_i |=> wr_ptr_i == $past(wr_ptr_i) + {{AW{1'b0}}, $past(wr_i)})
    else begin $error("write pointer stepped wrongly"); fail_cnt++; end

  a_rd_step: assert property (@(posedge clk) disable iff (!nrst)
    !reset_i |=> rd_ptr_i == $past(rd_ptr_i) + {{AW{1'b0}}, $past(rd_i)})
    else begin $error("read pointer stepped wrongly"); fail_cnt++; end

  a_flush: assert property (@(posedge clk) disable iff (!nrst)
    reset_i |=> (wr_ptr_i == '0) && (rd_ptr_i == '0))
    else begin $error("flush left the pointers set"); fail_cnt++; end

endmodule

bind fifo_buffer fifo_buffer_chk u_chk (
  .clk(clk), .nrst(nrst), .reset_i(reset_i), .wr_i(wr_i), .rd_i(rd_i),
  .empty_i(empty_o), .full_i(full_o), .wr_ptr_i(wr_ptr), .rd_ptr_i(rd_ptr)
);

`default_nettype wire

// ==== testbench/nibble_stream_tb.sv ====
////////////////////////////////////////////////////////////
// Nibble stream testbench: table of pushes, takes and
// register accesses checked against a queue model
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "nib_defs.svh"

module nibble_stream_tb
  import nib_reg_pkg::*;
();

  localparam int OP_PUSH  = 0;
  localparam int OP_RAND  = 1;
  localparam int OP_TAKE  = 2;
  localparam int OP_WRITE = 3;
  localparam int OP_READ  = 4;
  localparam int HI       = 1 << CTRL_HI_FIRST;
  localparam int FLUSH    = 1 << CTRL_FLUSH;

  // exp below zero means the model predicts the value
  typedef struct packed {
    int op;
    int data;
    int rep;
    int exp;
  } row_t;

  logic       clk;
  logic       nrst;
  logic       nib_valid_i;
  logic [3:0] nib_i;
  logic       nib_take_i;
  logic       nib_valid_o;
  logic [3:0] nib_o;
  logic       reg_we_i;
  logic [1:0] reg_addr_i;
  logic [7:0] reg_wdata_i;
  logic [7:0] reg_rdata_o;

  // Reference model state
  logic [7:0] words_q[$];
  logic       pend;
  logic [3:0] pend_nib;
  logic       out_phase;
  logic       hi_first_m;
  logic [7:0] drops_m;
  row_t       rows_q[$];
  int         seed = 5;

  nibble_stream_top dut (
    .clk(clk), .nrst(nrst), .nib_valid_i(nib_valid_i), .nib_i(nib_i),
    .nib_take_i(nib_take_i), .nib_valid_o(nib_valid_o), .nib_o(nib_o),
    .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [7:0] exp_v,
                           input logic [7:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("FAIL %s expected %02h actual %02h", name, exp_v, act_v));
    end
  endtask

  task automatic wait_valid(input string name);
    int n;
    n = 0;
    while (!nib_valid_o && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!nib_valid_o) begin
      stop_run({name, ": nib_valid_o stayed low although data was stored"});
    end
  endtask

  task automatic add_row(input int op, input int data, input int rep, input int exp);
    row_t r;
    r.op   = op;
    r.data = data;
    r.rep  = rep;
    r.exp  = exp;
    rows_q.push_back(r);
  endtask

  // Pairs of nibbles become words, first nibble placed by hi_first
  task automatic store_nibble(input logic [3:0] d);
    if (!pend) begin
      pend     = 1'b1;
      pend_nib = d;
    end else begin
      pend = 1'b0;
      if (words_q.size() == `FIFO_DEPTH) begin
        if (drops_m != 8'hFF) begin
          drops_m = drops_m + 8'd1;
        end
      end else if (hi_first_m) begin
        words_q.push_back({pend_nib, d});
      end else begin
        words_q.push_back({d, pend_nib});
      end
    end
  endtask

  task automatic take_nibble(input string name);
    logic [7:0] w;
    logic [3:0] exp_n;
    if (words_q.size() == 0) begin
      check_val({name, " valid"}, 8'h00, {7'h00, nib_valid_o});
    end else begin
      w = words_q[0];
      if (out_phase) begin
        exp_n = hi_first_m ? w[3:0] : w[7:4];
      end else begin
        exp_n = hi_first_m ? w[7:4] : w[3:0];
      end
      check_val({name, " nib_o"}, {4'h0, exp_n}, {4'h0, nib_o});
      if (out_phase) begin
        w = words_q.pop_front();
      end
      out_phase = ~out_phase;
    end
  endtask

  function automatic logic [7:0] expected_reg(input logic [1:0] addr);
    logic [7:0] v;
    v = 8'h00;
    if (addr == REG_CTRL) begin
      v[CTRL_HI_FIRST] = hi_first_m;
    end else if (addr == REG_STATUS) begin
      v[4:0] = 5'(words_q.size());
      v[6]   = (words_q.size() == 0);
      v[7]   = (words_q.size() == `FIFO_DEPTH);
    end else if (addr == REG_DROPS) begin
      v = drops_m;
    end else if (words_q.size() != 0) begin
      v = words_q[0];
    end
    return v;
  endfunction

  // One strobe cycle, outputs checked at the falling edge
  task automatic run_op(input string name, input row_t r);
    logic [3:0] nib;
    logic [7:0] exp_v;
    nib = r.data[3:0];
    if (r.op == OP_RAND) begin
      nib = 4'($random(seed));
    end
    if (r.op == OP_TAKE && words_q.size() != 0) begin
      wait_valid(name);
    end
    @(posedge clk);
    case (r.op)
      OP_PUSH, OP_RAND: begin
        nib_valid_i <= 1'b1;
        nib_i       <= nib;
      end
      OP_TAKE: nib_take_i <= 1'b1;
      OP_WRITE: begin
        reg_we_i    <= 1'b1;
        reg_addr_i  <= REG_CTRL;
        reg_wdata_i <= r.data[7:0];
      end
      default: reg_addr_i <= r.data[1:0];
    endcase
    @(negedge clk);
    case (r.op)
      OP_PUSH, OP_RAND: store_nibble(nib);
      OP_TAKE: take_nibble(name);
      OP_WRITE: begin
        hi_first_m = r.data[CTRL_HI_FIRST];
        if (r.data[CTRL_FLUSH]) begin
          words_q.delete();
          pend      = 1'b0;
          out_phase = 1'b0;
        end
      end
      default: begin
        exp_v = (r.exp >= 0) ? r.exp[7:0] : expected_reg(r.data[1:0]);
        check_val(name, exp_v, reg_rdata_o);
      end
    endcase
    @(posedge clk);
    nib_valid_i <= 1'b0;
    nib_take_i  <= 1'b0;
    reg_we_i    <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    nrst        = 1'b0;
    nib_valid_i = 1'b0;
    nib_i       = 4'h0;
    nib_take_i  = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = 2'd0;
    reg_wdata_i = 8'h00;
    pend        = 1'b0;
    pend_nib    = 4'h0;
    out_phase   = 1'b0;
    hi_first_m  = 1'b1;
    drops_m     = 8'h00;
    // Reset state
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    add_row(OP_READ, REG_DROPS, 1, 0);
    add_row(OP_TAKE, 0, 1, -1);
    // High nibble first
    add_row(OP_PUSH, 'h3, 1, -1);
    add_row(OP_PUSH, 'hA, 1, -1);
    add_row(OP_PUSH, 'h5, 1, -1);
    add_row(OP_PUSH, 'hC, 1, -1);
    add_row(OP_READ, REG_HEAD, 1, 'h3A);
    add_row(OP_READ, REG_STATUS, 1, 'h02);
    add_row(OP_TAKE, 0, 4, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    // Low nibble first
    add_row(OP_WRITE, 0, 1, -1);
    add_row(OP_PUSH, 'h6, 1, -1);
    add_row(OP_PUSH, 'h9, 1, -1);
    add_row(OP_PUSH, 'h1, 1, -1);
    add_row(OP_PUSH, 'hE, 1, -1);
    add_row(OP_READ, REG_HEAD, 1, 'h96);
    add_row(OP_READ, REG_CTRL, 1, 0);
    add_row(OP_TAKE, 0, 4, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    // Overflow, last two words dropped
    add_row(OP_WRITE, HI, 1, -1);
    add_row(OP_RAND, 0, 36, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h90);
    add_row(OP_READ, REG_DROPS, 1, 2);
    add_row(OP_TAKE, 0, 32, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    // Interleaved traffic
    add_row(OP_RAND, 0, 3, -1);
    add_row(OP_TAKE, 0, 1, -1);
    add_row(OP_READ, REG_STATUS, 1, -1);
    add_row(OP_RAND, 0, 5, -1);
    add_row(OP_READ, REG_STATUS, 1, -1);
    add_row(OP_TAKE, 0, 3, -1);
    add_row(OP_READ, REG_STATUS, 1, -1);
    add_row(OP_RAND, 0, 2, -1);
    add_row(OP_TAKE, 0, 2, -1);
    add_row(OP_READ, REG_STATUS, 1, -1);
    // Flush with both phases mid-word
    add_row(OP_RAND, 0, 3, -1);
    add_row(OP_TAKE, 0, 1, -1);
    add_row(OP_WRITE, HI | FLUSH, 1, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    add_row(OP_TAKE, 0, 2, -1);
    add_row(OP_PUSH, 'h7, 1, -1);
    add_row(OP_PUSH, 'h2, 1, -1);
    add_row(OP_READ, REG_HEAD, 1, 'h72);
    add_row(OP_TAKE, 0, 2, -1);
    add_row(OP_READ, REG_STATUS, 1, 'h40);
    add_row(OP_READ, REG_DROPS, 1, 2);

    repeat (4) @(posedge clk);
    nrst <= 1'b1;
    @(negedge clk);
    foreach (rows_q[i]) begin
      for (int k = 0; k < rows_q[i].rep; k++) begin
        run_op($sformatf("row %0d", i), rows_q[i]);
      end
    end
    if (dut.u_fifo.u_chk.fail_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      stop_run("FIFO checker reported failed assertions");
    end
  end

endmodule

`default_nettype wire

// ==== nibble_stream_top.f ====
+incdir+src
src/nib_data_pkg.sv
src/nib_reg_pkg.sv
src/nibble_packer.sv
src/fifo_buffer.sv
src/nibble_unpacker.sv
src/stream_regs.sv
src/nibble_stream_top.sv
testbench/fifo_buffer_chk.sv
testbench/nibble_stream_tb.sv

// ==== Makefile ====
TOP = nibble_stream_tb

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --assert -f nibble_stream_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
